// ==== logic/lsu_params.svh ====
// data width, data RAM depth and RAM response latency macros
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 64

// 64-bit words in the data RAM
`define LSU_RAM_DEPTH 256

// cycles from request handshake to response valid
`define LSU_RAM_LATENCY 3

`endif

// ==== logic/lsu_pkg.sv ====
// access size enum and load/store controller state enum
`default_nettype none

package lsu_pkg;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0, // 1 byte
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3  // full dword
  } mem_size_e;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_WR_REQ  = 3'd1,
    ST_WR_RESP = 3'd2,
    ST_RD_REQ  = 3'd3,
    ST_RD_DATA = 3'd4
  } lsu_state_e;

endpackage

`default_nettype wire

// ==== logic/lsu_align.sv ====
// store lane shifting and byte mask, load extraction with sign or zero extension
`timescale 1ns/1ps
`default_nettype none
`include "lsu_params.svh"

module lsu_align (
  input  wire [`LSU_XLEN-1:0]       st_addr_i,
  input  wire [`LSU_XLEN-1:0]       st_data_i,
  input  wire lsu_pkg::mem_size_e   st_size_i,
  input  wire lsu_pkg::mem_size_e   ld_size_i,
  input  wire                       ld_sext_i,
  input  wire [`LSU_XLEN-1:0]       rdata_i,
  output logic [`LSU_XLEN-1:0]      wr_data_o,
  output logic [`LSU_XLEN/8-1:0]    wr_mask_o,
  output logic [`LSU_XLEN-1:0]      ld_value_o
);

  localparam int NBYTES = `LSU_XLEN / 8;
  localparam int OFF_W  = $clog2(NBYTES);

  logic [OFF_W-1:0]     offset;
  logic [OFF_W+2:0]     shamt;
  logic [NBYTES-1:0]    size_mask;
  logic [`LSU_XLEN-1:0] ld_shifted;
  logic                 fill;

  assign offset = st_addr_i[OFF_W-1:0];
  assign shamt  = {offset, 3'b000}; // byte offset in bits

  always_comb begin
    case (st_size_i)
      lsu_pkg::SIZE_B: size_mask = NBYTES'(1);
      lsu_pkg::SIZE_H: size_mask = NBYTES'(3);
      lsu_pkg::SIZE_W: size_mask = NBYTES'(15);
      default:         size_mask = '1;
    endcase
  end

  assign wr_mask_o = size_mask << offset;
  assign wr_data_o = st_data_i << shamt;

  // addressed bytes land at bit 0
  assign ld_shifted = rdata_i >> shamt;

  always_comb begin
    case (ld_size_i)
      lsu_pkg::SIZE_B: begin
        fill       = ld_sext_i & ld_shifted[7];
        ld_value_o = {{(`LSU_XLEN-8){fill}}, ld_shifted[7:0]};
      end
      lsu_pkg::SIZE_H: begin
        fill       = ld_sext_i & ld_shifted[15];
        ld_value_o = {{(`LSU_XLEN-16){fill}}, ld_shifted[15:0]};
      end
      lsu_pkg::SIZE_W: begin
        fill       = ld_sext_i & ld_shifted[31];
        ld_value_o = {{(`LSU_XLEN-32){fill}}, ld_shifted[31:0]};
      end
      default: begin
        fill       = 1'b0; // dword, nothing to extend
        ld_value_o = ld_shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/lsu_ctrl.sv ====
// load/store FSM driving the bus handshakes, stall level and load data capture
`timescale 1ns/1ps
`default_nettype none
`include "lsu_params.svh"

module lsu_ctrl (
  input  wire                       clk,
  input  wire                       arst_n_i,
  input  wire                       req_i,
  input  wire                       req_we_i,
  input  wire [`LSU_XLEN-1:0]       req_addr_i,
  input  wire [`LSU_XLEN-1:0]       req_wdata_i,
  input  wire lsu_pkg::mem_size_e   req_size_i,
  input  wire                       req_sext_i,
  output logic [`LSU_XLEN-1:0]      st_addr_o,
  output logic [`LSU_XLEN-1:0]      st_data_o,
  output lsu_pkg::mem_size_e        st_size_o,
  output lsu_pkg::mem_size_e        ld_size_o,
  output logic                      ld_sext_o,
  input  wire [`LSU_XLEN-1:0]       ld_value_i,
  output logic                      wr_valid_o,
  output logic [`LSU_XLEN-1:0]      wr_addr_o,
  input  wire                       wr_ready_i,
  input  wire                       wresp_valid_i,
  output logic                      wresp_ready_o,
  output logic                      rd_valid_o,
  output logic [`LSU_XLEN-1:0]      rd_addr_o,
  input  wire                       rd_ready_i,
  input  wire                       rdata_valid_i,
  output logic                      rdata_ready_o,
  output logic                      stall_o,
  output logic                      load_valid_o,
  output logic [`LSU_XLEN-1:0]      load_data_o
);

  lsu_pkg::lsu_state_e  state_q;
  logic [`LSU_XLEN-1:0] addr_q;
  logic [`LSU_XLEN-1:0] wdata_q;
  lsu_pkg::mem_size_e   size_q;
  logic                 sext_q;
  logic                 wresp_ready_q;
  logic                 rdata_ready_q;
  logic                 load_valid_q;
  logic [`LSU_XLEN-1:0] load_data_q;
  logic                 accept;
  logic                 wr_hs;
  logic                 wresp_hs;
  logic                 rd_hs;
  logic                 rdata_hs;

  assign accept   = req_i && (state_q == lsu_pkg::ST_IDLE); // strobes while busy are dropped
  assign wr_hs    = wr_valid_o && wr_ready_i;
  assign wresp_hs = wresp_valid_i && wresp_ready_q;
  assign rd_hs    = rd_valid_o && rd_ready_i;
  assign rdata_hs = rdata_valid_i && rdata_ready_q;

  // held request, also feeds the aligner
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      size_q  <= req_size_i;
      sext_q  <= req_sext_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= lsu_pkg::ST_IDLE;
      wresp_ready_q <= 1'b0;
      rdata_ready_q <= 1'b0;
      load_valid_q  <= 1'b0;
      load_data_q   <= '0;
    end else begin
      load_valid_q <= 1'b0;
      case (state_q)
        lsu_pkg::ST_IDLE:
          if (accept) state_q <= req_we_i ? lsu_pkg::ST_WR_REQ : lsu_pkg::ST_RD_REQ;
        lsu_pkg::ST_WR_REQ:
          if (wr_hs) state_q <= lsu_pkg::ST_WR_RESP;
        lsu_pkg::ST_WR_RESP: begin
          if (wresp_hs) begin
            wresp_ready_q <= 1'b0;
            state_q       <= lsu_pkg::ST_IDLE;
          end else if (wresp_valid_i) begin
            wresp_ready_q <= 1'b1; // one cycle behind valid
          end
        end
        lsu_pkg::ST_RD_REQ:
          if (rd_hs) state_q <= lsu_pkg::ST_RD_DATA;
        lsu_pkg::ST_RD_DATA: begin
          if (rdata_hs) begin
            rdata_ready_q <= 1'b0;
            load_valid_q  <= 1'b1;
            load_data_q   <= ld_value_i;
            state_q       <= lsu_pkg::ST_IDLE;
          end else if (rdata_valid_i) begin
            rdata_ready_q <= 1'b1;
          end
        end
        default: state_q <= lsu_pkg::ST_IDLE;
      endcase
    end
  end

  assign st_addr_o     = addr_q;
  assign st_data_o     = wdata_q;
  assign st_size_o     = size_q;
  assign ld_size_o     = size_q;
  assign ld_sext_o     = sext_q;
  assign wr_valid_o    = (state_q == lsu_pkg::ST_WR_REQ);
  assign wr_addr_o     = addr_q;
  assign wresp_ready_o = wresp_ready_q;
  assign rd_valid_o    = (state_q == lsu_pkg::ST_RD_REQ);
  assign rd_addr_o     = addr_q;
  assign rdata_ready_o = rdata_ready_q;
  assign stall_o       = (state_q != lsu_pkg::ST_IDLE);
  assign load_valid_o  = load_valid_q;
  assign load_data_o   = load_data_q;

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
// word-addressed data RAM slave with byte-masked writes and fixed response latency
`timescale 1ns/1ps
`default_nettype none
`include "lsu_params.svh"

module data_ram (
  input  wire                       clk,
  input  wire                       arst_n_i,
  input  wire                       wr_valid_i,
  input  wire [`LSU_XLEN-1:0]       wr_addr_i,
  input  wire [`LSU_XLEN-1:0]       wr_data_i,
  input  wire [`LSU_XLEN/8-1:0]     wr_mask_i,
  output logic                      wr_ready_o,
  input  wire                       wresp_ready_i,
  output logic                      wresp_valid_o,
  input  wire                       rd_valid_i,
  input  wire [`LSU_XLEN-1:0]       rd_addr_i,
  output logic                      rd_ready_o,
  input  wire                       rdata_ready_i,
  output logic                      rdata_valid_o,
  output logic [`LSU_XLEN-1:0]      rdata_o
);

  localparam int NBYTES = `LSU_XLEN / 8;
  localparam int OFF_W  = $clog2(NBYTES);
  localparam int IDX_W  = $clog2(`LSU_RAM_DEPTH);
  localparam int CNT_W  = $clog2(`LSU_RAM_LATENCY + 1);

  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_DEPTH];
  logic [`LSU_XLEN-1:0] rdata_q;
  logic [IDX_W-1:0]     wr_idx;
  logic [IDX_W-1:0]     rd_idx;

  // channel 0 is write, channel 1 is read
  logic [1:0]       req_valid;
  logic [1:0]       req_ready_q;
  logic [1:0]       req_hs;
  logic [1:0]       resp_ready;
  logic [1:0]       resp_valid_q;
  logic [1:0]       busy;
  logic [CNT_W-1:0] cnt_q [2];

  assign req_valid  = {rd_valid_i, wr_valid_i};
  assign resp_ready = {rdata_ready_i, wresp_ready_i};
  assign req_hs     = req_valid & req_ready_q;

  assign wr_idx = wr_addr_i[OFF_W +: IDX_W]; // wraps modulo depth
  assign rd_idx = rd_addr_i[OFF_W +: IDX_W];

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      busy[c] = (cnt_q[c] != '0) || resp_valid_q[c];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_ready_q  <= '0;
      resp_valid_q <= '0;
      for (int c = 0; c < 2; c++) begin
        cnt_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        req_ready_q[c] <= req_valid[c] && !req_ready_q[c] && !busy[c];
        if (req_hs[c]) cnt_q[c] <= CNT_W'(`LSU_RAM_LATENCY);
        else if (cnt_q[c] != '0) cnt_q[c] <= cnt_q[c] - 1'b1;
        if (cnt_q[c] == CNT_W'(1)) resp_valid_q[c] <= 1'b1;
        else if (resp_valid_q[c] && resp_ready[c]) resp_valid_q[c] <= 1'b0;
      end
    end
  end

  // storage and read capture at the request handshake
  always_ff @(posedge clk) begin
    if (req_hs[0]) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wr_mask_i[b]) mem[wr_idx][b*8 +: 8] <= wr_data_i[b*8 +: 8];
      end
    end
    if (req_hs[1]) rdata_q <= mem[rd_idx];
  end

  assign wr_ready_o    = req_ready_q[0];
  assign rd_ready_o    = req_ready_q[1];
  assign wresp_valid_o = resp_valid_q[0];
  assign rdata_valid_o = resp_valid_q[1];
  assign rdata_o       = rdata_q; // held while rdata_valid_o is high

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
// load/store unit top with controller, aligner and data RAM
`timescale 1ns/1ps
`default_nettype none
`include "lsu_params.svh"

module lsu_top (
  input  wire                       clk,
  input  wire                       arst_n_i,
  input  wire                       req_i,
  input  wire                       req_we_i,
  input  wire [`LSU_XLEN-1:0]       req_addr_i,
  input  wire [`LSU_XLEN-1:0]       req_wdata_i,
  input  wire lsu_pkg::mem_size_e   req_size_i,
  input  wire                       req_sext_i,
  output logic                      stall_o,
  output logic                      load_valid_o,
  output logic [`LSU_XLEN-1:0]      load_data_o
);

  // bus between controller and RAM
  logic                   wr_valid, wr_ready;
  logic [`LSU_XLEN-1:0]   wr_addr, wr_data;
  logic [`LSU_XLEN/8-1:0] wr_mask;
  logic                   wresp_valid, wresp_ready;
  logic                   rd_valid, rd_ready;
  logic [`LSU_XLEN-1:0]   rd_addr;
  logic                   rdata_valid, rdata_ready;
  logic [`LSU_XLEN-1:0]   rdata;

  // controller to aligner
  logic [`LSU_XLEN-1:0]   st_addr, st_data, ld_value;
  lsu_pkg::mem_size_e     st_size, ld_size;
  logic                   ld_sext;

  lsu_ctrl lsu_ctrl_inst (
    .clk, .arst_n_i, .req_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_size_i, .req_sext_i,
    .st_addr_o(st_addr), .st_data_o(st_data), .st_size_o(st_size),
    .ld_size_o(ld_size), .ld_sext_o(ld_sext), .ld_value_i(ld_value),
    .wr_valid_o(wr_valid), .wr_addr_o(wr_addr), .wr_ready_i(wr_ready),
    .wresp_valid_i(wresp_valid), .wresp_ready_o(wresp_ready),
    .rd_valid_o(rd_valid), .rd_addr_o(rd_addr), .rd_ready_i(rd_ready),
    .rdata_valid_i(rdata_valid), .rdata_ready_o(rdata_ready),
    .stall_o, .load_valid_o, .load_data_o
  );

  lsu_align lsu_align_inst (
    .st_addr_i(st_addr), .st_data_i(st_data), .st_size_i(st_size),
    .ld_size_i(ld_size), .ld_sext_i(ld_sext), .rdata_i(rdata),
    .wr_data_o(wr_data), .wr_mask_o(wr_mask), .ld_value_o(ld_value)
  );

  data_ram data_ram_inst (
    .clk, .arst_n_i,
    .wr_valid_i(wr_valid), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .wr_mask_i(wr_mask),
    .wr_ready_o(wr_ready), .wresp_ready_i(wresp_ready), .wresp_valid_o(wresp_valid),
    .rd_valid_i(rd_valid), .rd_addr_i(rd_addr), .rd_ready_o(rd_ready),
    .rdata_ready_i(rdata_ready), .rdata_valid_o(rdata_valid), .rdata_o(rdata)
  );

endmodule

`default_nettype wire

// ==== dv/lsu_checker.sv ====
// concurrent assertions on the LSU bus handshakes, stall level and reset values
`timescale 1ns/1ps
`default_nettype none
`include "lsu_params.svh"

module lsu_checker (
  input wire                      clk,
  input wire                      arst_n_i,
  input wire lsu_pkg::lsu_state_e state_i,
  input wire                      wr_valid_i,
  input wire                      wr_ready_i,
  input wire [`LSU_XLEN-1:0]      wr_addr_i,
  input wire [`LSU_XLEN-1:0]      wr_data_i,
  input wire lsu_pkg::mem_size_e  wr_size_i,
  input wire                      rd_valid_i,
  input wire                      rd_ready_i,
  input wire [`LSU_XLEN-1:0]      rd_addr_i,
  input wire                      wresp_valid_i,
  input wire                      wresp_ready_i,
  input wire                      rdata_valid_i,
  input wire                      rdata_ready_i,
  input wire                      stall_i,
  input wire                      load_valid_i
);

  int fail_count;

  initial fail_count = 0;

  wr_req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_addr_i)
      && $stable(wr_data_i) && $stable(wr_size_i))
    else begin
      fail_count++;
      $error("write request dropped or changed before ready");
    end

  rd_req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_addr_i))
    else begin
      fail_count++;
      $error("read request dropped or changed before ready");
    end

  // responses from the RAM held through the late ready
  wresp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wresp_valid_i && !wresp_ready_i |=> wresp_valid_i)
    else begin
      fail_count++;
      $error("write response valid dropped before ready");
    end

  rdata_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    rdata_valid_i && !rdata_ready_i |=> rdata_valid_i)
    else begin
      fail_count++;
      $error("read data valid dropped before ready");
    end

  // response readies cleared on return to idle
  idle_no_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    state_i == lsu_pkg::ST_IDLE |-> !stall_i && !wr_valid_i && !rd_valid_i
      && !wresp_ready_i && !rdata_ready_i)
    else begin
      fail_count++;
      $error("stall or bus activity while idle");
    end

  one_request: assert property (@(posedge clk) disable iff (!arst_n_i)
    !((wr_valid_i || wresp_ready_i) && (rd_valid_i || rdata_ready_i)))
    else begin
      fail_count++;
      $error("read and write channels active together");
    end

  reset_quiet: assert property (@(posedge clk)
    !arst_n_i |-> !stall_i && !load_valid_i)
    else begin
      fail_count++;
      $error("stall or load valid high in reset");
    end

endmodule

bind lsu_ctrl lsu_checker lsu_checker_inst (
  .clk(clk), .arst_n_i(arst_n_i), .state_i(state_q),
  .wr_valid_i(wr_valid_o), .wr_ready_i(wr_ready_i), .wr_addr_i(wr_addr_o),
  .wr_data_i(st_data_o), .wr_size_i(st_size_o),
  .rd_valid_i(rd_valid_o), .rd_ready_i(rd_ready_i), .rd_addr_i(rd_addr_o),
  .wresp_valid_i(wresp_valid_i), .wresp_ready_i(wresp_ready_o),
  .rdata_valid_i(rdata_valid_i), .rdata_ready_i(rdata_ready_o),
  .stall_i(stall_o), .load_valid_i(load_valid_o)
);

`default_nettype wire

// ==== dv/lsu_tb.sv ====
// testbench for the load/store unit with byte reference model and load compare
`timescale 1ns/1ps
`default_nettype none
`include "lsu_params.svh"

module lsu_tb;

  localparam int XLEN          = `LSU_XLEN;
  localparam int MODEL_BYTES   = `LSU_RAM_DEPTH * 8;
  localparam int STALL_TIMEOUT = 64;
  localparam int RAND_BASE     = 'h400; // 64 dwords for the random mix

  logic               clk;
  logic               arst_n_i;
  logic               req_i;
  logic               req_we_i;
  logic [XLEN-1:0]    req_addr_i;
  logic [XLEN-1:0]    req_wdata_i;
  lsu_pkg::mem_size_e req_size_i;
  logic               req_sext_i;
  logic               stall_o;
  logic               load_valid_o;
  logic [XLEN-1:0]    load_data_o;

  logic [7:0]      model_mem [MODEL_BYTES]; // mirrors the data RAM bytes
  logic [XLEN-1:0] exp_q [$];
  int              loads_issued;
  int              pulse_count;

  lsu_top lsu_top_inst (
    .clk, .arst_n_i, .req_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_size_i,
    .req_sext_i, .stall_o, .load_valid_o, .load_data_o
  );

  always #4 clk = ~clk;

  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                             input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
    return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], ~addr[31:0]};
  endfunction

  // expected load value from the byte model
  function automatic logic [XLEN-1:0] load_ref(input logic [XLEN-1:0] addr,
                                               input lsu_pkg::mem_size_e size,
                                               input logic sext);
    int          nbytes;
    logic [XLEN-1:0] value;
    nbytes = 1 << int'(size);
    value  = '0;
    for (int i = 0; i < nbytes; i++) begin
      value[8*i +: 8] = model_mem[int'(addr) + i];
    end
    if (sext && nbytes < 8 && value[8*nbytes-1]) begin
      value = value | ({XLEN{1'b1}} << (8 * nbytes));
    end
    return value;
  endfunction

  task automatic wait_for_stall(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > STALL_TIMEOUT) begin
        $display("timeout: stall_o did not go to %0b within %0d cycles", level, STALL_TIMEOUT);
        stop_with_failure();
      end
    end while (stall_o !== level);
  endtask

  task automatic do_access(input logic we, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata, input lsu_pkg::mem_size_e size,
                           input logic sext);
    int nbytes;
    nbytes = 1 << int'(size);
    if (we) begin
      for (int i = 0; i < nbytes; i++) begin
        model_mem[int'(addr) + i] = wdata[8*i +: 8];
      end
    end else begin
      exp_q.push_back(load_ref(addr, size, sext));
      loads_issued++;
    end
    @(posedge clk);
    req_i       <= 1'b1;
    req_we_i    <= we;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    req_size_i  <= size;
    req_sext_i  <= sext;
    @(posedge clk);
    req_i <= 1'b0;
    wait_for_stall(1'b1);
    wait_for_stall(1'b0);
    @(posedge clk);
    check_value("stall_o", XLEN'(stall_o), '0); // one fall per access
    check_value("load pulse count", XLEN'(pulse_count), XLEN'(loads_issued));
  endtask

  always @(posedge clk) begin : compare_loads
    logic [XLEN-1:0] expected;
    if (lsu_top_inst.lsu_ctrl_inst.lsu_checker_inst.fail_count != 0) begin
      $display("an assertion in lsu_checker failed");
      stop_with_failure();
    end
    if (arst_n_i && load_valid_o) begin
      pulse_count++;
      if (exp_q.size() == 0) begin
        $display("load_valid_o pulsed with no load outstanding");
        stop_with_failure();
      end else begin
        expected = exp_q.pop_front();
        check_value("load_data_o", load_data_o, expected);
      end
    end
  end

  initial begin : stimulus
    logic [XLEN-1:0]    addr;
    logic [XLEN-1:0]    data;
    lsu_pkg::mem_size_e size;
    int                 nbytes;
    void'($urandom(32'h424d_90e7));
    clk          = 1'b0;
    arst_n_i     = 1'b0;
    req_i        = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_size_i   = lsu_pkg::SIZE_D;
    req_sext_i   = 1'b0;
    loads_issued = 0;
    pulse_count  = 0;
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk);

    // dword round trip
    do_access(1'b1, 'h100, 64'hfedc_ba98_7654_3210, lsu_pkg::SIZE_D, 1'b0);
    do_access(1'b0, 'h100, '0, lsu_pkg::SIZE_D, 1'b0);
    data = {$urandom, $urandom};
    do_access(1'b1, 'h108, data, lsu_pkg::SIZE_D, 1'b0);
    do_access(1'b0, 'h108, '0, lsu_pkg::SIZE_D, 1'b0);

    // partial stores into one dword
    do_access(1'b1, 'h40, fill_word('h40), lsu_pkg::SIZE_D, 1'b0);
    for (int s = 0; s < 3; s++) begin
      size   = lsu_pkg::mem_size_e'(s);
      nbytes = 1 << s;
      for (int off = 0; off < 8; off += nbytes) begin
        do_access(1'b1, 'h40 + off, {$urandom, $urandom}, size, 1'b0);
        do_access(1'b0, 'h40, '0, lsu_pkg::SIZE_D, 1'b0);
      end
    end

    // extension with every top bit set, then every top bit clear
    for (int p = 0; p < 2; p++) begin
      data = (p == 0) ? 64'hf1e2_d3c4_b5a6_9788 : 64'h7162_5344_3526_1708;
      do_access(1'b1, 'h80, data, lsu_pkg::SIZE_D, 1'b0);
      for (int s = 0; s < 3; s++) begin
        size   = lsu_pkg::mem_size_e'(s);
        nbytes = 1 << s;
        for (int off = 0; off < 8; off += nbytes) begin
          do_access(1'b0, 'h80 + off, '0, size, 1'b0);
          do_access(1'b0, 'h80 + off, '0, size, 1'b1);
        end
      end
    end

    // random mix over a filled region
    for (int a = RAND_BASE; a < RAND_BASE + 512; a += 8) begin
      do_access(1'b1, a, fill_word(a), lsu_pkg::SIZE_D, 1'b0);
    end
    for (int n = 0; n < 200; n++) begin
      size   = lsu_pkg::mem_size_e'($urandom_range(3));
      nbytes = 1 << int'(size);
      addr   = RAND_BASE + ($urandom_range(511) & ~(nbytes - 1)); // aligned to size
      data   = {$urandom, $urandom};
      do_access(1'($urandom_range(1)), addr, data, size, 1'($urandom_range(1)));
    end

    repeat (4) @(posedge clk);
    check_value("load pulse count", XLEN'(pulse_count), XLEN'(loads_issued));
    check_value("pending loads", XLEN'(exp_q.size()), '0);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/lsu_ctrl.sv
logic/data_ram.sv
logic/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

// ==== Makefile ====
# Verilator flow for the load/store unit testbench
TOP := lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
